// File: hdl/ps2_mouse_pkg.sv
`default_nettype none

package ps2_mouse_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [7:0] ps2_byte_t;

  // Byte 0 sits in the top bits, then the X delta, then the Y delta
  typedef logic [23:0] packet_t;

  typedef logic signed [8:0] delta_t;
  typedef logic [8:0] coord_t;

  // Left, right and middle in bits 0, 1 and 2
  typedef logic [2:0] buttons_t;

  typedef logic [1:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Protocol bytes and register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam ps2_byte_t CMD_ENABLE = 8'hF4;
  localparam ps2_byte_t RSP_ACK = 8'hFA;

  localparam reg_addr_t ADDR_STATUS = 2'd0;
  localparam reg_addr_t ADDR_X = 2'd1;
  localparam reg_addr_t ADDR_Y = 2'd2;

endpackage

`default_nettype wire

// File: hdl/ps2_host_tx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_host_tx #(
  parameter int INHIBIT_CYCLES = 1000
) (
  input  logic clk,
  input  logic rst,
  input  logic ps2_clk_in,
  output logic clk_drive_low,
  output logic data_drive_low,
  output logic tx_done
);
  import ps2_mouse_pkg::*;

  localparam int CNT_W = $clog2(INHIBIT_CYCLES + 1);

  // Odd parity over the command byte
  localparam logic PARITY_BIT = ~^CMD_ENABLE;

  typedef enum logic [2:0] {
    ST_INHIBIT,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP,
    ST_DONE
  } tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] hold_cnt;
  logic [2:0]       bit_cnt;
  logic [1:0]       clk_sync;
  logic             clk_prev;
  logic             clk_fall;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Device clock synchronizer and fall detect
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_sync <= 2'b11;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2_clk_in};
      clk_prev <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The device samples on its rising edge, so each new bit is put on
  // the data line right after a falling edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state          <= ST_INHIBIT;
      hold_cnt       <= '0;
      bit_cnt        <= '0;
      clk_drive_low  <= 1'b0;
      data_drive_low <= 1'b0;
      tx_done        <= 1'b0;
    end else begin
      case (state)
        ST_INHIBIT: begin
          clk_drive_low <= 1'b1;
          hold_cnt      <= hold_cnt + 1'b1;
          if (hold_cnt == CNT_W'(INHIBIT_CYCLES)) begin
            // Release the clock and hold data low as the request-to-send
            state          <= ST_START;
            clk_drive_low  <= 1'b0;
            data_drive_low <= 1'b1;
          end
        end
        ST_START: begin
          if (clk_fall) begin
            state          <= ST_DATA;
            bit_cnt        <= '0;
            data_drive_low <= ~CMD_ENABLE[0];
          end
        end
        ST_DATA: begin
          if (clk_fall) begin
            if (bit_cnt == 3'd7) begin
              state          <= ST_PARITY;
              data_drive_low <= ~PARITY_BIT;
            end else begin
              bit_cnt        <= bit_cnt + 1'b1;
              data_drive_low <= ~CMD_ENABLE[bit_cnt + 3'd1];
            end
          end
        end
        ST_PARITY: begin
          if (clk_fall) begin
            // Stop bit is a released line
            state          <= ST_STOP;
            data_drive_low <= 1'b0;
          end
        end
        ST_STOP: begin
          // The next fall is the line-ack clock from the device
          if (clk_fall) begin
            state   <= ST_DONE;
            tx_done <= 1'b1;
          end
        end
        default: begin
          state <= ST_DONE;
        end
      endcase
    end
  end

  // Once the inhibit is over the host never pulls both lines at once
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    (state != ST_INHIBIT) |-> !(clk_drive_low && data_drive_low));

endmodule

`default_nettype wire

// File: hdl/ps2_frame_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_rx (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ps2_clk_in,
  input  logic                   ps2_data_in,
  input  logic                   tx_done,
  output logic                   pkt_valid,
  output ps2_mouse_pkg::packet_t pkt,
  output logic                   ack_seen,
  output logic                   parity_err
);
  import ps2_mouse_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_t;

  rx_state_t  state;
  logic [1:0] clk_sync;
  logic [1:0] data_sync;
  logic       clk_prev;
  logic       clk_fall;
  logic       line_data;
  logic [2:0] bit_cnt;
  ps2_byte_t  shift_reg;
  logic       par_bit;
  logic       par_ok;
  logic       ack_armed;
  logic [1:0] byte_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Line synchronizers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk_in};
      data_sync <= {data_sync[0], ps2_data_in};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall  = clk_prev & ~clk_sync[1];
  assign line_data = data_sync[1];

  // Eight data bits and the parity bit together hold an odd number of ones
  assign par_ok = ^{shift_reg, par_bit};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame FSM and packet assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      ack_armed  <= 1'b0;
      pkt_valid  <= 1'b0;
      ack_seen   <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      pkt_valid  <= 1'b0;
      ack_seen   <= 1'b0;
      parity_err <= 1'b0;
      if (clk_fall) begin
        case (state)
          ST_IDLE: begin
            // The host's own command frame is on the lines until tx_done
            if (tx_done && !line_data) begin
              state   <= ST_DATA;
              bit_cnt <= '0;
            end
          end
          ST_DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= ST_PARITY;
            end
          end
          ST_PARITY: begin
            state <= ST_STOP;
          end
          ST_STOP: begin
            state <= ST_IDLE;
            if (!par_ok) begin
              // Drop whatever part of a packet was collected
              parity_err <= 1'b1;
              byte_cnt   <= '0;
            end else if (!ack_armed) begin
              if (shift_reg == RSP_ACK) begin
                ack_seen  <= 1'b1;
                ack_armed <= 1'b1;
                byte_cnt  <= '0;
              end
            end else if (byte_cnt == 2'd2) begin
              pkt_valid <= 1'b1;
              byte_cnt  <= '0;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clk_fall) begin
      if (state == ST_DATA) begin
        shift_reg <= {line_data, shift_reg[7:1]};
      end
      if (state == ST_PARITY) begin
        par_bit <= line_data;
      end
      if ((state == ST_STOP) && par_ok && ack_armed) begin
        case (byte_cnt)
          2'd0: pkt[23:16] <= shift_reg;
          2'd1: pkt[15:8] <= shift_reg;
          default: pkt[7:0] <= shift_reg;
        endcase
      end
    end
  end

  // Movement packets only follow a finished command and its acknowledge
  a_pkt_after_ack: assert property (@(posedge clk) disable iff (rst)
    pkt_valid |-> (ack_armed && tx_done));

endmodule

`default_nettype wire

// File: hdl/mouse_position.sv
`timescale 1ns/1ns
`default_nettype none

module mouse_position #(
  parameter int X_MAX = 409,
  parameter int Y_MAX = 307
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pkt_valid,
  input  ps2_mouse_pkg::packet_t  pkt,
  output ps2_mouse_pkg::buttons_t buttons,
  output ps2_mouse_pkg::coord_t   pos_x,
  output ps2_mouse_pkg::coord_t   pos_y,
  output logic                    pkt_new
);
  import ps2_mouse_pkg::*;

  // Room for a 9-bit coordinate plus or minus a 9-bit delta
  typedef logic signed [10:0] wide_t;

  delta_t dx;
  delta_t dy;
  wide_t  sum_x;
  wide_t  sum_y;

  function automatic coord_t clamp(input wide_t value, input int limit);
    if (value < 0) begin
      return '0;
    end else if (value > limit) begin
      return coord_t'(limit);
    end else begin
      return value[8:0];
    end
  endfunction

  // Sign bits live in byte 0, bit 4 for X and bit 5 for Y
  assign dx = {pkt[20], pkt[15:8]};
  assign dy = {pkt[21], pkt[7:0]};

  assign sum_x = wide_t'({2'b00, pos_x}) + wide_t'(dx);

  // Screen Y grows downward while mouse Y grows upward
  assign sum_y = wide_t'({2'b00, pos_y}) - wide_t'(dy);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos_x   <= coord_t'(X_MAX / 2);
      pos_y   <= coord_t'(Y_MAX / 2);
      buttons <= '0;
      pkt_new <= 1'b0;
    end else begin
      pkt_new <= pkt_valid;
      if (pkt_valid) begin
        pos_x   <= clamp(sum_x, X_MAX);
        pos_y   <= clamp(sum_y, Y_MAX);
        buttons <= pkt[18:16];
      end
    end
  end

  a_in_bounds: assert property (@(posedge clk) disable iff (rst)
    (pos_x <= coord_t'(X_MAX)) && (pos_y <= coord_t'(Y_MAX)));

endmodule

`default_nettype wire

// File: hdl/mouse_regs.sv
`timescale 1ns/1ns
`default_nettype none

module mouse_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cs,
  input  ps2_mouse_pkg::reg_addr_t addr,
  output ps2_mouse_pkg::reg_data_t rdata,
  input  ps2_mouse_pkg::buttons_t  buttons,
  input  ps2_mouse_pkg::coord_t    pos_x,
  input  ps2_mouse_pkg::coord_t    pos_y,
  input  logic                     pkt_new,
  input  logic                     ack_seen,
  input  logic                     tx_done,
  input  logic                     parity_err
);
  import ps2_mouse_pkg::*;

  logic      new_flag;
  logic      perr_flag;
  logic      enabled;
  logic      status_rd;
  reg_data_t status;

  assign status_rd = cs && (addr == ADDR_STATUS);
  assign status    = {10'd0, perr_flag, enabled, new_flag, buttons};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      new_flag  <= 1'b0;
      perr_flag <= 1'b0;
      enabled   <= 1'b0;
      rdata     <= '0;
    end else begin
      // A pulse in the same cycle as the clearing read wins
      new_flag  <= pkt_new | (new_flag & ~status_rd);
      perr_flag <= parity_err | (perr_flag & ~status_rd);
      enabled   <= enabled | (ack_seen & tx_done);
      if (cs) begin
        case (addr)
          ADDR_STATUS: rdata <= status;
          ADDR_X: rdata <= reg_data_t'(pos_x);
          ADDR_Y: rdata <= reg_data_t'(pos_y);
          default: rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/ps2_mouse.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse #(
  parameter int INHIBIT_CYCLES = 1000,
  parameter int X_MAX = 409,
  parameter int Y_MAX = 307
) (
  input  logic                     clk,
  input  logic                     rst,
  inout  wire                      ps2_clk,
  inout  wire                      ps2_data,
  input  logic                     cs,
  input  ps2_mouse_pkg::reg_addr_t addr,
  output ps2_mouse_pkg::reg_data_t rdata
);
  import ps2_mouse_pkg::*;

  logic     clk_drive_low;
  logic     data_drive_low;
  logic     tx_done;
  logic     pkt_valid;
  packet_t  pkt;
  logic     ack_seen;
  logic     parity_err;
  buttons_t buttons;
  coord_t   pos_x;
  coord_t   pos_y;
  logic     pkt_new;

  // Open-drain pins, pulled high on the board
  assign ps2_clk  = clk_drive_low ? 1'b0 : 1'bz;
  assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

  ps2_host_tx #(
    .INHIBIT_CYCLES(INHIBIT_CYCLES)
  ) u_tx (
    .clk           (clk),
    .rst           (rst),
    .ps2_clk_in    (ps2_clk),
    .clk_drive_low (clk_drive_low),
    .data_drive_low(data_drive_low),
    .tx_done       (tx_done)
  );

  ps2_frame_rx u_rx (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk_in (ps2_clk),
    .ps2_data_in(ps2_data),
    .tx_done    (tx_done),
    .pkt_valid  (pkt_valid),
    .pkt        (pkt),
    .ack_seen   (ack_seen),
    .parity_err (parity_err)
  );

  mouse_position #(
    .X_MAX(X_MAX),
    .Y_MAX(Y_MAX)
  ) u_pos (
    .clk      (clk),
    .rst      (rst),
    .pkt_valid(pkt_valid),
    .pkt      (pkt),
    .buttons  (buttons),
    .pos_x    (pos_x),
    .pos_y    (pos_y),
    .pkt_new  (pkt_new)
  );

  mouse_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .cs        (cs),
    .addr      (addr),
    .rdata     (rdata),
    .buttons   (buttons),
    .pos_x     (pos_x),
    .pos_y     (pos_y),
    .pkt_new   (pkt_new),
    .ack_seen  (ack_seen),
    .tx_done   (tx_done),
    .parity_err(parity_err)
  );

endmodule

`default_nettype wire

// File: bench/ps2_device_model.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_device_model (
  input wire clk,
  inout wire ps2_clk,
  inout wire ps2_data
);
  // Half of one device clock period in system cycles
  localparam int HALF_CYCLES = 10;

  logic clk_low = 1'b0;
  logic data_low = 1'b0;

  assign ps2_clk  = clk_low ? 1'b0 : 1'bz;
  assign ps2_data = data_low ? 1'b0 : 1'bz;

  task automatic half_period();
    repeat (HALF_CYCLES) @(posedge clk);
    #10;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host to device command
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic take_command(output logic [7:0] value, output logic parity_ok);
    logic [9:0] frame;
    // Request-to-send is a released clock with data held low
    while (!(ps2_clk == 1'b1 && ps2_data == 1'b0)) begin
      @(posedge clk);
    end
    #10;
    // Data bits, parity and stop are read at the end of each low phase
    for (int i = 0; i < 10; i++) begin
      half_period();
      clk_low = 1'b1;
      half_period();
      frame[i] = ps2_data;
      clk_low = 1'b0;
    end
    // Line acknowledge
    half_period();
    data_low = 1'b1;
    clk_low = 1'b1;
    half_period();
    clk_low = 1'b0;
    data_low = 1'b0;
    half_period();
    value = frame[7:0];
    parity_ok = (^frame[8:0]) && frame[9];
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Device to host frame
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_frame(input logic [7:0] value, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
    // The host samples each bit on the falling clock edge
    for (int i = 0; i < 11; i++) begin
      data_low = ~bits[i];
      half_period();
      clk_low = 1'b1;
      half_period();
      clk_low = 1'b0;
    end
    data_low = 1'b0;
    half_period();
  endtask

endmodule

`default_nettype wire

// File: bench/ps2_mouse_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_tb;
  import ps2_mouse_pkg::*;

  localparam int INHIBIT = 40;
  localparam int X_MAX = 409;
  localparam int Y_MAX = 307;
  localparam int RAND_PKTS = 40;
  localparam int CLAMP_PKTS = 4;
  // Command, acknowledge, then three frames per packet
  localparam int FRAMES = 2 + 3 * (RAND_PKTS + 2 * CLAMP_PKTS + 3);
  localparam int WATCHDOG_CYCLES = FRAMES * 11 * 20 * 2 + INHIBIT;

  logic      clk;
  logic      rst;
  logic      cs;
  reg_addr_t addr;
  reg_data_t rdata;
  wire       ps2_clk;
  wire       ps2_data;

  int seed = 32'h783e_56a8;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_errors = 0;
  int exp_x;
  int exp_y;
  int exp_btn;
  int got_x;
  int got_y;

  pullup (ps2_clk);
  pullup (ps2_data);

  ps2_mouse #(
    .INHIBIT_CYCLES(INHIBIT),
    .X_MAX         (X_MAX),
    .Y_MAX         (Y_MAX)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .ps2_clk (ps2_clk),
    .ps2_data(ps2_data),
    .cs      (cs),
    .addr    (addr),
    .rdata   (rdata)
  );

  ps2_device_model u_model (
    .clk     (clk),
    .ps2_clk (ps2_clk),
    .ps2_data(ps2_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int clamp_ref(input int value, input int limit);
    if (value < 0) begin
      return 0;
    end
    if (value > limit) begin
      return limit;
    end
    return value;
  endfunction

  task automatic compare_value(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("[%s] finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
    tests++;
  endtask

  // Read data is captured one cycle after cs
  task automatic read_reg(input reg_addr_t a, output reg_data_t d);
    @(posedge clk);
    #10;
    cs = 1'b1;
    addr = a;
    @(posedge clk);
    #10;
    cs = 1'b0;
    d = rdata;
  endtask

  task automatic wait_status(input string name, input int bit_idx, output reg_data_t st);
    int polls;
    polls = 0;
    read_reg(ADDR_STATUS, st);
    while (!st[bit_idx] && polls < 20) begin
      read_reg(ADDR_STATUS, st);
      polls++;
    end
    if (!st[bit_idx]) begin
      $display("%s: status bit %0d was never set", name, bit_idx);
      errors++;
    end
  endtask

  task automatic check_position(input string name);
    reg_data_t val;
    read_reg(ADDR_X, val);
    got_x = int'(val);
    compare_value({name, " x"}, exp_x, got_x);
    read_reg(ADDR_Y, val);
    got_y = int'(val);
    compare_value({name, " y"}, exp_y, got_y);
  endtask

  task automatic send_packet(input buttons_t btn, input delta_t dx, input delta_t dy,
                             input logic bad_last);
    u_model.send_frame({2'b00, dy[8], dx[8], 1'b1, btn}, 1'b0);
    u_model.send_frame(dx[7:0], 1'b0);
    u_model.send_frame(dy[7:0], bad_last);
  endtask

  task automatic apply_packet(input string name, input buttons_t btn, input delta_t dx,
                              input delta_t dy);
    reg_data_t st;
    send_packet(btn, dx, dy, 1'b0);
    exp_x = clamp_ref(exp_x + int'(dx), X_MAX);
    exp_y = clamp_ref(exp_y - int'(dy), Y_MAX);
    exp_btn = int'(btn);
    wait_status(name, 3, st);
    compare_value({name, " status"}, 'h18 + exp_btn, int'(st));
    check_position(name);
  endtask

  task automatic random_packet(input string name);
    apply_packet(name, 3'($random(seed)), 9'($random(seed)), 9'($random(seed)));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    reg_data_t st;
    ps2_byte_t cmd;
    logic      par_ok;
    rst = 1'b1;
    cs = 1'b0;
    addr = ADDR_STATUS;
    exp_x = 204;
    exp_y = 153;
    exp_btn = 0;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    read_reg(ADDR_STATUS, st);
    compare_value("reset status", 0, int'(st));
    check_position("reset");
    finish_test("reset");

    u_model.take_command(cmd, par_ok);
    compare_value("enable command", int'(CMD_ENABLE), int'(cmd));
    compare_value("enable parity", 1, int'(par_ok));
    u_model.send_frame(RSP_ACK, 1'b0);
    wait_status("enable", 4, st);
    compare_value("enable status", 'h10, int'(st));
    finish_test("enable");

    for (int i = 0; i < RAND_PKTS; i++) begin
      random_packet("random");
    end
    finish_test("random");

    // Plus 255 on both axes pushes X up and screen Y down
    for (int i = 0; i < CLAMP_PKTS; i++) begin
      apply_packet("clamp up", 3'b000, 9'h0FF, 9'h0FF);
    end
    compare_value("clamp x max", X_MAX, got_x);
    compare_value("clamp y min", 0, got_y);
    for (int i = 0; i < CLAMP_PKTS; i++) begin
      apply_packet("clamp down", 3'b000, 9'h100, 9'h100);
    end
    compare_value("clamp x min", 0, got_x);
    compare_value("clamp y max", Y_MAX, got_y);
    finish_test("clamp");

    // Corrupting the last byte keeps the next packet aligned
    send_packet(3'($random(seed)), 9'($random(seed)), 9'($random(seed)), 1'b1);
    wait_status("parity", 5, st);
    compare_value("parity status", 'h30 + exp_btn, int'(st));
    check_position("parity");
    random_packet("parity recovery");
    finish_test("parity");

    random_packet("sticky");
    read_reg(ADDR_STATUS, st);
    compare_value("sticky clear", 'h10 + exp_btn, int'(st));
    finish_test("sticky");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
hdl/ps2_mouse_pkg.sv
hdl/ps2_host_tx.sv
hdl/ps2_frame_rx.sv
hdl/mouse_position.sv
hdl/mouse_regs.sv
hdl/ps2_mouse.sv
bench/ps2_device_model.sv
bench/ps2_mouse_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module ps2_mouse_tb -f src.f -o sim_ps2_mouse
	./obj_dir/sim_ps2_mouse | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
